// File: Makefile
VERILATOR = verilator
LINTFLAGS = --lint-only --timing --assert
SIMFLAGS  = --binary --timing --assert
TOP       = video_tb
FILELIST  = sim.f
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/video_assert.sv
module video_assert (
	input logic clk,
	input logic reset,
	input logic rd,
	input logic rdata_valid,
	input logic vblank_irq,
	input logic stat_irq
);
	timeunit 1ns;
	timeprecision 100ps;

	vblank_single: assert property (@(posedge clk) disable iff (reset) vblank_irq |=> !vblank_irq)
		else $error("vblank_irq high on two cycles in a row");

	stat_single: assert property (@(posedge clk) disable iff (reset) stat_irq |=> !stat_irq)
		else $error("stat_irq high on two cycles in a row");

	read_valid: assert property (@(posedge clk) disable iff (reset) rd |=> rdata_valid)
		else $error("rdata_valid missing one cycle after a read strobe");

	valid_from_read: assert property (@(posedge clk) disable iff (reset) !rd |=> !rdata_valid)
		else $error("rdata_valid without a read strobe");

endmodule

// unused inputs tied low on each side
bind lcd_status video_assert u_irq_assert (
	.clk         (clk),
	.reset       (reset),
	.rd          (1'b0),
	.rdata_valid (1'b0),
	.vblank_irq  (vblank_irq),
	.stat_irq    (stat_irq)
);

bind video_regs video_assert u_read_assert (
	.clk         (clk),
	.reset       (reset),
	.rd          (req.rd),
	.rdata_valid (rdata_valid),
	.vblank_irq  (1'b0),
	.stat_irq    (1'b0)
);

// File: bench/video_tb.sv
module video_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int dots_per_line  = 20;
	localparam int oam_dots       = 4;
	localparam int transfer_dots  = 8;
	localparam int visible_lines  = 4;
	localparam int total_lines    = 6;
	localparam int frame_cycles   = dots_per_line * total_lines;
	localparam int timeout_cycles = 3 * frame_cycles + 200;

	logic                 clk = 1'b0;
	logic                 reset;
	video_pkg::cpu_req_t  req;
	logic [7:0]           rdata;
	logic                 rdata_valid;
	video_pkg::lcd_regs_t regs;
	logic                 vblank_irq;
	logic                 stat_irq;

	integer seed = 32'h0a360575;
	int     cycle_count = 0;
	int     vblank_seen = 0;
	int     stat_seen = 0;

	logic [7:0] m_reg [16]; // model of the DUT state after the last edge
	int         m_dot;
	int         m_ly;
	int         m_ly_q;
	logic       m_active;
	logic       m_coin;
	logic       m_cond_q;
	int         m_vblank_cnt;
	int         m_stat_cnt;
	logic [7:0]           exp_q [$];
	video_pkg::reg_addr_e addr_q [$];

	video_top #(
		.dots_per_line (dots_per_line),
		.oam_dots      (oam_dots),
		.transfer_dots (transfer_dots),
		.visible_lines (visible_lines),
		.total_lines   (total_lines)
	) dut (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.regs        (regs),
		.vblank_irq  (vblank_irq),
		.stat_irq    (stat_irq)
	);

	always #10 clk = ~clk;

	function automatic video_pkg::lcd_mode_e mode_rule(input int line, input int dot);
		if (line >= visible_lines)
			return video_pkg::mode_vblank;
		else if (dot < oam_dots)
			return video_pkg::mode_oam_scan;
		else if (dot < oam_dots + transfer_dots)
			return video_pkg::mode_transfer;
		return video_pkg::mode_hblank;
	endfunction

	function automatic video_pkg::lcd_mode_e model_mode();
		return m_active ? mode_rule(m_ly, m_dot) : video_pkg::mode_hblank; // held while off
	endfunction

	function automatic logic [7:0] expected_read(input video_pkg::reg_addr_e a);
		logic [7:0] v;
		case (a)
			video_pkg::addr_stat: v = {1'b1, m_reg[video_pkg::addr_stat][6:3], m_coin, model_mode()};
			video_pkg::addr_ly:   v = 8'(m_ly);
			video_pkg::addr_ctrl, video_pkg::addr_scy, video_pkg::addr_scx,
			video_pkg::addr_lyc, video_pkg::addr_wy, video_pkg::addr_wx:
				v = m_reg[a];
			default:              v = 8'hFF;
		endcase
		return v;
	endfunction

	function automatic video_pkg::lcd_regs_t model_regs();
		video_pkg::lcd_regs_t r;
		r.ctrl    = m_reg[video_pkg::addr_ctrl];
		r.stat_en = m_reg[video_pkg::addr_stat][6:3];
		r.scy     = m_reg[video_pkg::addr_scy];
		r.scx     = m_reg[video_pkg::addr_scx];
		r.lyc     = m_reg[video_pkg::addr_lyc];
		r.wy      = m_reg[video_pkg::addr_wy];
		r.wx      = m_reg[video_pkg::addr_wx];
		return r;
	endfunction

	function automatic logic stat_condition();
		video_pkg::lcd_mode_e m;
		logic [7:0]           en;
		m  = model_mode();
		en = m_reg[video_pkg::addr_stat];
		return (m_coin && en[6]) || (m == video_pkg::mode_oam_scan && en[5]) ||
		       (m == video_pkg::mode_vblank && en[4]) || (m == video_pkg::mode_hblank && en[3]);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_run($sformatf("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_stat(input video_pkg::lcd_stat_t got, input video_pkg::lcd_stat_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error at %0d ns: stat = %b, expected %b", $time, got, exp));
	endtask

	task automatic check_regs(input video_pkg::lcd_regs_t got, input video_pkg::lcd_regs_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error at %0d ns: regs = %h, expected %h", $time, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic write_reg(input video_pkg::reg_addr_e a, input logic [7:0] d);
		@(posedge clk);
		req <= '{rd: 1'b0, wr: 1'b1, addr: a, wdata: d};
	endtask

	task automatic read_reg(input video_pkg::reg_addr_e a);
		@(posedge clk);
		req <= '{rd: 1'b1, wr: 1'b0, addr: a, wdata: 8'h00};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			req <= '0;
		end
	endtask

	// reference model sampled with the same pre-edge values the DUT sees
	always @(posedge clk) begin
		logic cond;
		if (reset) begin
			for (int i = 0; i < 16; i++)
				m_reg[i] = 8'h00;
			m_dot        = 0;
			m_ly         = 0;
			m_ly_q       = 0;
			m_active     = 1'b0;
			m_coin       = 1'b0;
			m_cond_q     = 1'b0;
			m_vblank_cnt = 0;
			m_stat_cnt   = 0;
		end else begin
			cond = stat_condition();
			if (req.rd) begin
				exp_q.push_back(expected_read(req.addr));
				addr_q.push_back(req.addr);
			end
			if (m_ly == visible_lines && m_ly_q != visible_lines)
				m_vblank_cnt++; // pulse one cycle after vblank starts
			if (cond && !m_cond_q)
				m_stat_cnt++;
			m_cond_q = cond;
			m_ly_q   = m_ly;
			m_coin   = (m_ly == int'(m_reg[video_pkg::addr_lyc]));
			if (m_reg[video_pkg::addr_ctrl][video_pkg::ctrl_enable_bit]) begin
				m_active = 1'b1;
				m_dot++;
				if (m_dot == dots_per_line) begin
					m_dot = 0;
					m_ly  = (m_ly + 1 == total_lines) ? 0 : m_ly + 1;
				end
			end else begin
				m_active = 1'b0;
				m_dot    = 0;
				m_ly     = 0;
			end
			if (req.wr) begin
				case (req.addr)
					video_pkg::addr_stat: m_reg[video_pkg::addr_stat] = req.wdata & 8'h78;
					video_pkg::addr_ctrl, video_pkg::addr_scy, video_pkg::addr_scx,
					video_pkg::addr_lyc, video_pkg::addr_wy, video_pkg::addr_wx:
						m_reg[req.addr] = req.wdata;
					default: ; // line register and holes
				endcase
			end
		end
	end

	always @(negedge clk) begin
		logic [7:0]           exp_v;
		video_pkg::reg_addr_e a;
		if (!reset) begin
			if (vblank_irq)
				vblank_seen++;
			if (stat_irq)
				stat_seen++;
			check_count("vblank_irq count", vblank_seen, m_vblank_cnt);
			check_count("stat_irq count", stat_seen, m_stat_cnt);
			check_regs(regs, model_regs());
			if (rdata_valid && exp_q.size() == 0) begin
				fail_run("rdata_valid was raised with no read pending");
			end else if (rdata_valid) begin
				exp_v = exp_q.pop_front();
				a     = addr_q.pop_front();
				if (a == video_pkg::addr_stat)
					check_stat(rdata[2:0], exp_v[2:0]);
				check_data("rdata", rdata, exp_v);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
			fail_run($sformatf("timeout: no end of test after %0d cycles", timeout_cycles));
	end

	initial begin
		logic [7:0]           data;
		video_pkg::reg_addr_e a;
		int                   vb_start;
		int                   st_start;
		reset = 1'b1;
		req   = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < 16; i++) begin
			data = 8'($random(seed));
			a    = video_pkg::reg_addr_e'(4'(i));
			if (a == video_pkg::addr_ctrl)
				data[video_pkg::ctrl_enable_bit] = 1'b0; // display stays off
			write_reg(a, data);
			read_reg(a);
		end

		read_reg(video_pkg::addr_ly);
		read_reg(video_pkg::addr_stat);
		write_reg(video_pkg::addr_ctrl, 8'h91);
		idle_cycles(25);
		read_reg(video_pkg::addr_ly);
		read_reg(video_pkg::addr_stat);

		write_reg(video_pkg::addr_lyc, 8'd2);
		write_reg(video_pkg::addr_stat, 8'h47); // coincidence irq only
		idle_cycles(3);
		vb_start = vblank_seen;
		st_start = stat_seen;
		for (int k = 0; k < 2 * frame_cycles; k++) begin
			if (k % 7 == 0)
				read_reg(video_pkg::addr_stat);
			else if (k % 7 == 3)
				read_reg(video_pkg::addr_ly);
			else
				idle_cycles(1);
		end
		check_count("vblank_irq over two frames", vblank_seen - vb_start, 2);
		check_count("stat_irq over two frames", stat_seen - st_start, 2);

		write_reg(video_pkg::addr_ctrl, 8'h11);
		idle_cycles(3);
		read_reg(video_pkg::addr_ly);
		read_reg(video_pkg::addr_stat);
		idle_cycles(1);
		vb_start = vblank_seen;
		st_start = stat_seen;
		idle_cycles(frame_cycles + 10);
		check_count("vblank_irq while off", vblank_seen - vb_start, 0);
		check_count("stat_irq while off", stat_seen - st_start, 0);
		idle_cycles(3);

		if (exp_q.size() != 0) begin
			fail_run($sformatf("%0d reads never returned data", exp_q.size()));
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// File: common/video_pkg.sv
package video_pkg;

	// video register offsets from the register base
	typedef enum logic [3:0] {
		addr_ctrl = 4'h0,
		addr_stat = 4'h1,
		addr_scy  = 4'h2,
		addr_scx  = 4'h3,
		addr_ly   = 4'h4, // read only
		addr_lyc  = 4'h5,
		addr_wy   = 4'hA,
		addr_wx   = 4'hB
	} reg_addr_e;

	typedef enum logic [1:0] {
		mode_hblank   = 2'd0,
		mode_vblank   = 2'd1,
		mode_oam_scan = 2'd2,
		mode_transfer = 2'd3
	} lcd_mode_e;

	typedef struct packed {
		logic       rd;
		logic       wr;
		reg_addr_e  addr;
		logic [7:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [7:0] ctrl;
		logic [3:0] stat_en; // status bits 6 to 3
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		logic [7:0] wy;
		logic [7:0] wx;
	} lcd_regs_t;

	typedef struct packed {
		logic [7:0]  ly;
		logic [15:0] dot;
		lcd_mode_e   mode;
	} line_pos_t;

	typedef struct packed {
		logic      coincidence;
		lcd_mode_e mode;
	} lcd_stat_t;

	localparam int ctrl_enable_bit = 7;

endpackage

// File: hdl/lcd_status.sv
module lcd_status #(
	parameter int visible_lines = 144
) (
	input  logic                 clk,
	input  logic                 reset,
	input  video_pkg::line_pos_t pos,
	input  video_pkg::lcd_regs_t regs,
	output video_pkg::lcd_stat_t stat,
	output logic [7:0]           ly,
	output logic                 vblank_irq,
	output logic                 stat_irq
);

	logic       coincidence;
	logic       stat_cond;
	logic       stat_cond_q;
	logic [7:0] ly_q;

	assign ly               = pos.ly;
	assign stat.coincidence = coincidence;
	assign stat.mode        = pos.mode;

	// stat_en[3] is bit 6, stat_en[0] is bit 3
	assign stat_cond = (coincidence && regs.stat_en[3]) ||
	                   (pos.mode == video_pkg::mode_oam_scan && regs.stat_en[2]) ||
	                   (pos.mode == video_pkg::mode_vblank && regs.stat_en[1]) ||
	                   (pos.mode == video_pkg::mode_hblank && regs.stat_en[0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			coincidence <= 1'b0;
			stat_cond_q <= 1'b0;
			ly_q        <= 8'd0;
			vblank_irq  <= 1'b0;
			stat_irq    <= 1'b0;
		end else begin
			coincidence <= (pos.ly == regs.lyc);
			stat_cond_q <= stat_cond;
			ly_q        <= pos.ly;
			stat_irq    <= stat_cond && !stat_cond_q; // rising edge only
			vblank_irq  <= (pos.ly == 8'(visible_lines)) && (ly_q != 8'(visible_lines));
		end
	end

endmodule

// File: hdl/line_timer.sv
module line_timer #(
	parameter int dots_per_line = 456,
	parameter int oam_dots      = 80,
	parameter int transfer_dots = 172,
	parameter int visible_lines = 144,
	parameter int total_lines   = 154
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [7:0]           ctrl,
	output video_pkg::line_pos_t pos
);

	logic        enable;
	logic [15:0] next_dot;
	logic [7:0]  next_ly;

	assign enable = ctrl[video_pkg::ctrl_enable_bit];

	function automatic video_pkg::lcd_mode_e mode_of(input logic [7:0] line,
	                                                 input logic [15:0] d);
		video_pkg::lcd_mode_e m;
		if (line >= 8'(visible_lines))
			m = video_pkg::mode_vblank;
		else if (d < 16'(oam_dots))
			m = video_pkg::mode_oam_scan;
		else if (d < 16'(oam_dots + transfer_dots))
			m = video_pkg::mode_transfer;
		else
			m = video_pkg::mode_hblank;
		return m;
	endfunction

	always_comb begin
		next_dot = pos.dot + 16'd1;
		next_ly  = pos.ly;
		if (pos.dot == 16'(dots_per_line - 1)) begin
			next_dot = 16'd0;
			if (pos.ly == 8'(total_lines - 1))
				next_ly = 8'd0; // end of frame
			else
				next_ly = pos.ly + 8'd1;
		end
	end

	// mode is computed from the next counter values so all three move together
	always_ff @(posedge clk) begin
		if (reset || !enable) begin
			pos.dot  <= 16'd0;
			pos.ly   <= 8'd0;
			pos.mode <= video_pkg::mode_hblank;
		end else begin
			pos.dot  <= next_dot;
			pos.ly   <= next_ly;
			pos.mode <= mode_of(next_ly, next_dot);
		end
	end

endmodule

// File: hdl/video_regs.sv
module video_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  video_pkg::cpu_req_t   req,
	input  logic [7:0]            ly,
	input  video_pkg::lcd_stat_t  stat,
	output video_pkg::lcd_regs_t  regs,
	output logic [7:0]            rdata,
	output logic                  rdata_valid
);

	logic we_ctrl;
	logic we_stat;
	logic we_scy;
	logic we_scx;
	logic we_lyc;
	logic we_wy;
	logic we_wx;
	logic [7:0] rd_value;

	// offset decode to per-register write enables
	always_comb begin
		we_ctrl = 1'b0;
		we_stat = 1'b0;
		we_scy  = 1'b0;
		we_scx  = 1'b0;
		we_lyc  = 1'b0;
		we_wy   = 1'b0;
		we_wx   = 1'b0;
		if (req.wr) begin
			case (req.addr)
				video_pkg::addr_ctrl: we_ctrl = 1'b1;
				video_pkg::addr_stat: we_stat = 1'b1;
				video_pkg::addr_scy:  we_scy  = 1'b1;
				video_pkg::addr_scx:  we_scx  = 1'b1;
				video_pkg::addr_lyc:  we_lyc  = 1'b1;
				video_pkg::addr_wy:   we_wy   = 1'b1;
				video_pkg::addr_wx:   we_wx   = 1'b1;
				default: ; // line register and holes ignore writes
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '0;
		end else begin
			if (we_ctrl)
				regs.ctrl <= req.wdata;
			if (we_stat)
				regs.stat_en <= req.wdata[6:3]; // low bits are read only
			if (we_scy)
				regs.scy <= req.wdata;
			if (we_scx)
				regs.scx <= req.wdata;
			if (we_lyc)
				regs.lyc <= req.wdata;
			if (we_wy)
				regs.wy <= req.wdata;
			if (we_wx)
				regs.wx <= req.wdata;
		end
	end

	always_comb begin
		case (req.addr)
			video_pkg::addr_ctrl: rd_value = regs.ctrl;
			video_pkg::addr_stat: rd_value = {1'b1, regs.stat_en, stat.coincidence, stat.mode};
			video_pkg::addr_scy:  rd_value = regs.scy;
			video_pkg::addr_scx:  rd_value = regs.scx;
			video_pkg::addr_ly:   rd_value = ly; // live line counter
			video_pkg::addr_lyc:  rd_value = regs.lyc;
			video_pkg::addr_wy:   rd_value = regs.wy;
			video_pkg::addr_wx:   rd_value = regs.wx;
			default:              rd_value = 8'hFF; // open bus
		endcase
	end

	// read data is valid for the one cycle after the strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			rdata       <= 8'h00;
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= req.rd;
			if (req.rd)
				rdata <= rd_value;
		end
	end

endmodule

// File: hdl/video_top.sv
module video_top #(
	parameter int dots_per_line = 456,
	parameter int oam_dots      = 80,
	parameter int transfer_dots = 172,
	parameter int visible_lines = 144,
	parameter int total_lines   = 154
) (
	input  logic                 clk,
	input  logic                 reset,
	input  video_pkg::cpu_req_t  req,
	output logic [7:0]           rdata,
	output logic                 rdata_valid,
	output video_pkg::lcd_regs_t regs,
	output logic                 vblank_irq,
	output logic                 stat_irq
);

	video_pkg::line_pos_t pos;
	video_pkg::lcd_stat_t stat;
	logic [7:0]           ly;

	video_regs u_regs (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.ly          (ly),
		.stat        (stat),
		.regs        (regs),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	line_timer #(
		.dots_per_line (dots_per_line),
		.oam_dots      (oam_dots),
		.transfer_dots (transfer_dots),
		.visible_lines (visible_lines),
		.total_lines   (total_lines)
	) u_timer (
		.clk   (clk),
		.reset (reset),
		.ctrl  (regs.ctrl),
		.pos   (pos)
	);

	lcd_status #(
		.visible_lines (visible_lines)
	) u_status (
		.clk        (clk),
		.reset      (reset),
		.pos        (pos),
		.regs       (regs),
		.stat       (stat),
		.ly         (ly),
		.vblank_irq (vblank_irq),
		.stat_irq   (stat_irq)
	);

endmodule

// File: sim.f
common/video_pkg.sv
hdl/video_regs.sv
hdl/line_timer.sv
hdl/lcd_status.sv
hdl/video_top.sv
bench/video_assert.sv
bench/video_tb.sv
